//--- Bender.yml
package:
  name: pix_controller

sources:
  - rtl/pix_pkg.sv
  - rtl/ctrl_pkg.sv
  - rtl/pix_capture.sv
  - rtl/pix_fifo.sv
  - rtl/frame_buffer.sv
  - rtl/pix_ctrl.sv
  - rtl/pix_controller.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/pix_controller_tb.sv

//--- list.f
rtl/pix_pkg.sv
rtl/ctrl_pkg.sv
rtl/pix_capture.sv
rtl/pix_fifo.sv
rtl/frame_buffer.sv
rtl/pix_ctrl.sv
rtl/pix_controller.sv
test/tb_clock.sv
test/pix_controller_tb.sv

//--- rtl/ctrl_pkg.sv
package ctrl_pkg;

    // ==============================
    // Wishbone classic slave port
    // ==============================
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;
        logic [15:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [15:0] dat;
    } wb_rsp_t;

    // ==============================
    // Register map
    // ==============================
    localparam logic [3:0] ADDR_CMD    = 4'd0;
    localparam logic [3:0] ADDR_STATUS = 4'd1;
    localparam logic [3:0] ADDR_DATA   = 4'd2;

    // Opcode sits in bits 1:0 of a command write, block in bits 4:3
    typedef enum logic [1:0] {
        CMD_NONE    = 2'd0,
        CMD_CAPTURE = 2'd1,
        CMD_READOUT = 2'd2
    } cmd_e;

    typedef struct packed {
        logic [12:0] zero;
        logic        readout_started;
        logic        pixel_dropped;
        logic        capture_done;
    } status_t;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_CAP_WAIT_FB,
        CTRL_CAP_ARM,
        CTRL_RD_FLUSH
    } ctrl_state_e;

endpackage

//--- rtl/frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer (
    input  logic               clk,
    input  logic               fifoIn_rst,
    input  pix_pkg::fb_cmd_t   cmd,
    input  logic               in_empty,
    input  pix_pkg::pix_word_t in_data,
    output logic               in_pop,
    input  logic               out_full,
    output pix_pkg::fifo_wr_t  out_wr,
    output logic               write_ready,
    output logic               write_done,
    output logic               read_busy
);

    pix_pkg::pix_word_t mem [pix_pkg::MEM_DEPTH];

    logic [$clog2(pix_pkg::REFRESH_INTERVAL)-1:0] ref_cnt;
    logic                                         refresh;
    logic                                         init_done;

    pix_pkg::fb_op_e                        mode;
    pix_pkg::blk_t                          block;
    logic [$clog2(pix_pkg::IMAGE_SIZE)-1:0] cnt;
    logic                                   seq_done;
    logic [$clog2(pix_pkg::MEM_DEPTH)-1:0]  addr;
    logic                                   mem_we;
    logic                                   rd_issue;
    logic                                   rd_valid;
    pix_pkg::pix_word_t                     rd_data;

    // ==============================
    // Refresh timing
    // ==============================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            ref_cnt   <= '0;
            init_done <= 1'b0;
        end else begin
            if (ref_cnt == pix_pkg::REFRESH_INTERVAL - 1) begin
                ref_cnt <= '0;
            end else begin
                ref_cnt <= ref_cnt + 1'b1;
            end
            // Memory counts as initialized after the first window
            if (!refresh) begin
                init_done <= 1'b1;
            end
        end
    end

    assign refresh = (ref_cnt < pix_pkg::REFRESH_CYCLES);

    // ==============================
    // Sequencers
    // ==============================
    assign addr = {block, cnt};

    // Extra pixels after a full block are still popped and dropped
    assign in_pop = !in_empty && (mode == pix_pkg::FB_WRITE) && !refresh;
    assign mem_we = in_pop && !seq_done;

    // Issue only when the in-flight slot frees up by next cycle
    assign rd_issue = (mode == pix_pkg::FB_READ) && !seq_done && !refresh
                      && (!rd_valid || !out_full);

    assign write_ready = init_done && (mode == pix_pkg::FB_WRITE) && !seq_done;
    assign read_busy   = (mode == pix_pkg::FB_READ) && (!seq_done || rd_valid);
    assign out_wr      = '{push: rd_valid && !out_full, data: rd_data};

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[addr] <= in_data;
        end
        if (rd_issue) begin
            rd_data <= mem[addr];
        end
    end

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            mode       <= pix_pkg::FB_NONE;
            block      <= '0;
            cnt        <= '0;
            seq_done   <= 1'b0;
            rd_valid   <= 1'b0;
            write_done <= 1'b0;
        end else begin
            write_done <= mem_we && (cnt == pix_pkg::IMAGE_SIZE - 1);

            if (rd_issue) begin
                rd_valid <= 1'b1;
            end else if (out_wr.push) begin
                rd_valid <= 1'b0;
            end

            if (cmd.op != pix_pkg::FB_NONE) begin
                mode     <= cmd.op;
                block    <= cmd.block;
                cnt      <= '0;
                seq_done <= 1'b0;
                rd_valid <= 1'b0;
            end else if (mem_we || rd_issue) begin
                cnt <= cnt + 1'b1;
                if (cnt == pix_pkg::IMAGE_SIZE - 1) begin
                    seq_done <= 1'b1;
                end
            end
        end
    end

    // A read held back by a full output FIFO keeps its word
    assert property (@(posedge clk) disable iff (!fifoIn_rst)
        (rd_valid && out_full && cmd.op == pix_pkg::FB_NONE) |=> (rd_valid && $stable(rd_data)));

endmodule

//--- rtl/pix_capture.sv
`timescale 1ns/1ps

module pix_capture (
    input  logic              clk,
    input  logic              fifoIn_rst,
    input  pix_pkg::pix_bus_t pix,
    input  logic              arm,
    input  logic              full,
    output pix_pkg::fifo_wr_t in_wr,
    output logic              started,
    output logic              dropped
);

    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_WAIT_LOW,
        CAP_WAIT_HIGH,
        CAP_ACTIVE
    } cap_state_e;

    cap_state_e        state;
    pix_pkg::pix_bus_t pix_q;
    logic              in_frame;
    logic              want_push;

    // Input register for the sensor bus
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            pix_q <= '0;
        end else begin
            pix_q <= pix;
        end
    end

    // Frame counts as started on the cycle fv is first seen high
    assign in_frame  = pix_q.fv && (state == CAP_WAIT_HIGH || state == CAP_ACTIVE);
    assign want_push = in_frame && pix_q.lv;

    assign in_wr = '{
        push: want_push && !full,
        data: {{($bits(pix_pkg::pix_word_t) - pix_pkg::PIX_BITS){1'b0}}, pix_q.data}
    };

    // ==============================
    // Frame sync FSM
    // ==============================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            state   <= CAP_IDLE;
            started <= 1'b0;
            dropped <= 1'b0;
        end else begin
            started <= 1'b0;

            case (state)
                // Skip a frame that is already running
                CAP_WAIT_LOW: begin
                    if (!pix_q.fv) begin
                        state <= CAP_WAIT_HIGH;
                    end
                end
                CAP_WAIT_HIGH: begin
                    if (pix_q.fv) begin
                        state <= CAP_ACTIVE;
                    end
                end
                CAP_ACTIVE: begin
                    if (!pix_q.fv) begin
                        state <= CAP_IDLE;
                    end
                end
                default: begin
                end
            endcase

            // Sticky until the next arm
            if (want_push && full) begin
                dropped <= 1'b1;
            end

            if (arm) begin
                state   <= CAP_WAIT_LOW;
                started <= 1'b1;
                dropped <= 1'b0;
            end
        end
    end

    // A pixel refused by the full FIFO marks the frame as damaged
    assert property (@(posedge clk) disable iff (!fifoIn_rst)
        (want_push && !in_wr.push && !arm) |=> dropped);

endmodule

//--- rtl/pix_controller.sv
`timescale 1ns/1ps

module pix_controller (
    input  logic              clk,
    input  logic              fifoIn_rst,
    input  pix_pkg::pix_bus_t pix,
    input  ctrl_pkg::wb_req_t wb_req,
    output ctrl_pkg::wb_rsp_t wb_rsp
);

    pix_pkg::fifo_wr_t  in_wr;
    pix_pkg::fifo_wr_t  out_wr;
    pix_pkg::pix_word_t in_data;
    pix_pkg::pix_word_t out_data;
    pix_pkg::fb_cmd_t   fb_cmd;
    logic               in_full;
    logic               in_empty;
    logic               in_pop;
    logic               out_full;
    logic               out_empty;
    logic               out_pop;
    logic               write_ready;
    logic               write_done;
    logic               arm;
    logic               flush_in;
    logic               flush_out;
    logic               started;
    logic               dropped;

    // ==============================
    // Pixel pipeline
    // ==============================
    pix_capture u_capture (
        .clk(clk), .fifoIn_rst(fifoIn_rst), .pix(pix), .arm(arm), .full(in_full),
        .in_wr(in_wr), .started(started), .dropped(dropped)
    );

    pix_fifo #(.DEPTH(pix_pkg::FIFO_IN_DEPTH)) fifo_in (
        .clk(clk), .fifoIn_rst(fifoIn_rst), .flush(flush_in), .wr(in_wr), .full(in_full),
        .pop(in_pop), .empty(in_empty), .rd_data(in_data)
    );

    // Read busy flag is not part of the register map
    frame_buffer u_frame_buffer (
        .clk(clk), .fifoIn_rst(fifoIn_rst), .cmd(fb_cmd), .in_empty(in_empty),
        .in_data(in_data), .in_pop(in_pop), .out_full(out_full), .out_wr(out_wr),
        .write_ready(write_ready), .write_done(write_done), .read_busy()
    );

    pix_fifo #(.DEPTH(pix_pkg::FIFO_OUT_DEPTH)) fifo_out (
        .clk(clk), .fifoIn_rst(fifoIn_rst), .flush(flush_out), .wr(out_wr), .full(out_full),
        .pop(out_pop), .empty(out_empty), .rd_data(out_data)
    );

    pix_ctrl u_ctrl (
        .clk(clk), .fifoIn_rst(fifoIn_rst), .wb_req(wb_req), .wb_rsp(wb_rsp),
        .fb_cmd(fb_cmd), .write_ready(write_ready), .write_done(write_done),
        .started(started), .dropped(dropped), .arm(arm), .flush_in(flush_in),
        .flush_out(flush_out), .out_empty(out_empty), .out_data(out_data), .out_pop(out_pop)
    );

endmodule

//--- rtl/pix_ctrl.sv
`timescale 1ns/1ps

module pix_ctrl (
    input  logic               clk,
    input  logic               fifoIn_rst,
    input  ctrl_pkg::wb_req_t  wb_req,
    output ctrl_pkg::wb_rsp_t  wb_rsp,
    output pix_pkg::fb_cmd_t   fb_cmd,
    input  logic               write_ready,
    input  logic               write_done,
    input  logic               started,
    input  logic               dropped,
    output logic               arm,
    output logic               flush_in,
    output logic               flush_out,
    input  logic               out_empty,
    input  pix_pkg::pix_word_t out_data,
    output logic               out_pop
);

    ctrl_pkg::ctrl_state_e state;
    ctrl_pkg::cmd_e        opcode;
    ctrl_pkg::status_t     status;
    pix_pkg::blk_t         cmd_block;
    logic                  capture_done;
    logic                  readout_started;
    logic                  ack_q;
    logic [15:0]           dat_q;
    logic                  req_valid;
    logic                  data_read;
    logic                  reg_access;
    logic                  cmd_write;

    // ==============================
    // Bus decode
    // ==============================
    assign req_valid  = wb_req.cyc && wb_req.stb && !ack_q;
    assign data_read  = req_valid && !wb_req.we && (wb_req.adr == ctrl_pkg::ADDR_DATA);
    assign reg_access = req_valid && !data_read;
    assign cmd_write  = reg_access && wb_req.we && (wb_req.adr == ctrl_pkg::ADDR_CMD);

    // Data reads wait here until the output FIFO has a word
    assign out_pop = data_read && !out_empty;

    assign opcode    = ctrl_pkg::cmd_e'(wb_req.dat[1:0]);
    assign cmd_block = wb_req.dat[4:3];

    always_comb begin
        status                 = '0;
        status.capture_done    = capture_done;
        status.pixel_dropped   = dropped;
        status.readout_started = readout_started;
    end

    assign wb_rsp = '{ack: ack_q, dat: dat_q};

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= reg_access || out_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (out_pop) begin
            dat_q <= out_data;
        end else if (reg_access) begin
            dat_q <= (wb_req.adr == ctrl_pkg::ADDR_STATUS) ? 16'(status) : '0;
        end
    end

    // ==============================
    // Command FSM
    // ==============================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            state           <= ctrl_pkg::CTRL_IDLE;
            fb_cmd          <= '{op: pix_pkg::FB_NONE, block: '0};
            arm             <= 1'b0;
            flush_in        <= 1'b0;
            flush_out       <= 1'b0;
            capture_done    <= 1'b0;
            readout_started <= 1'b0;
        end else begin
            fb_cmd.op <= pix_pkg::FB_NONE;
            arm       <= 1'b0;
            flush_in  <= 1'b0;
            flush_out <= 1'b0;

            if (write_done) begin
                capture_done <= 1'b1;
            end

            case (state)
                // Frame buffer must have taken the command first
                ctrl_pkg::CTRL_CAP_WAIT_FB: begin
                    if (fb_cmd.op == pix_pkg::FB_NONE && write_ready) begin
                        flush_in <= 1'b1;
                        arm      <= 1'b1;
                        state    <= ctrl_pkg::CTRL_CAP_ARM;
                    end
                end
                ctrl_pkg::CTRL_CAP_ARM: begin
                    if (started) begin
                        state <= ctrl_pkg::CTRL_IDLE;
                    end
                end
                ctrl_pkg::CTRL_RD_FLUSH: begin
                    readout_started <= 1'b1;
                    state           <= ctrl_pkg::CTRL_IDLE;
                end
                default: begin
                end
            endcase

            // A new command overrides whatever is running
            if (cmd_write) begin
                case (opcode)
                    ctrl_pkg::CMD_CAPTURE: begin
                        capture_done    <= 1'b0;
                        readout_started <= 1'b0;
                        fb_cmd          <= '{op: pix_pkg::FB_WRITE, block: cmd_block};
                        state           <= ctrl_pkg::CTRL_CAP_WAIT_FB;
                    end
                    ctrl_pkg::CMD_READOUT: begin
                        readout_started <= 1'b0;
                        fb_cmd          <= '{op: pix_pkg::FB_READ, block: cmd_block};
                        flush_out       <= 1'b1;
                        state           <= ctrl_pkg::CTRL_RD_FLUSH;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    assert property (@(posedge clk) disable iff (!fifoIn_rst) wb_rsp.ack |-> wb_req.stb);

endmodule

//--- rtl/pix_fifo.sv
`timescale 1ns/1ps

module pix_fifo #(
    parameter int DEPTH = 8
) (
    input  logic               clk,
    input  logic               fifoIn_rst,
    input  logic               flush,
    input  pix_pkg::fifo_wr_t  wr,
    output logic               full,
    input  logic               pop,
    output logic               empty,
    output pix_pkg::pix_word_t rd_data
);

    pix_pkg::pix_word_t         mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       do_push;
    logic                       do_pop;

    assign full    = (count == DEPTH);
    assign empty   = (count == 0);
    assign do_push = wr.push && !full;
    assign do_pop  = pop && !empty;

    // Show-ahead read puts the head word on rd_data
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!fifoIn_rst) pop |-> !empty);

endmodule

//--- rtl/pix_pkg.sv
package pix_pkg;

    // ==============================
    // Sensor and stored pixel
    // ==============================
    localparam int PIX_BITS = 12;

    // Pixel with four zero bits above it
    typedef logic [15:0] pix_word_t;

    typedef struct packed {
        logic [PIX_BITS-1:0] data;
        logic                fv;
        logic                lv;
    } pix_bus_t;

    // ==============================
    // Frame buffer geometry
    // ==============================
    localparam int IMAGE_SIZE       = 64;
    localparam int BLOCK_COUNT      = 4;
    localparam int MEM_DEPTH        = IMAGE_SIZE * BLOCK_COUNT;
    localparam int REFRESH_INTERVAL = 48;
    localparam int REFRESH_CYCLES   = 12;
    localparam int FIFO_IN_DEPTH    = 8;
    localparam int FIFO_OUT_DEPTH   = 8;

    typedef logic [1:0] blk_t;

    typedef enum logic [1:0] {FB_NONE, FB_WRITE, FB_READ} fb_op_e;

    typedef struct packed {
        fb_op_e op;
        blk_t   block;
    } fb_cmd_t;

    typedef struct packed {
        logic      push;
        pix_word_t data;
    } fifo_wr_t;

endpackage

//--- test/pix_controller_tb.sv
`timescale 1ns/1ps

module pix_controller_tb;

    // ==============================
    // Frame shape and run limit
    // ==============================
    localparam int DRIVE_DELAY = 10;
    localparam int LEAD_IN     = 16;
    localparam int LINE_LEN    = 8;
    localparam int LINE_GAP    = 8;
    localparam int TAIL        = 8;
    localparam int SLOW_GAP    = 20;
    localparam int LINES       = pix_pkg::IMAGE_SIZE / LINE_LEN;

    localparam int GAPPED_FRAME = LEAD_IN + 2 + pix_pkg::IMAGE_SIZE + (LINES - 1) * LINE_GAP + TAIL;
    localparam int FLAT_FRAME   = LEAD_IN + 2 + pix_pkg::IMAGE_SIZE + TAIL
                                  + pix_pkg::REFRESH_INTERVAL;
    localparam int SKIP_FRAME   = 4 + 2 * (LINE_LEN + LINE_GAP);
    localparam int FAST_READ    = pix_pkg::IMAGE_SIZE * 4;
    localparam int SLOW_READ    = pix_pkg::IMAGE_SIZE * (SLOW_GAP + 4);
    localparam int TIMEOUT_CYCLES = 4 * (6 * GAPPED_FRAME + FLAT_FRAME + SKIP_FRAME
                                         + 5 * FAST_READ + SLOW_READ);

    logic              clk;
    logic              fifoIn_rst;
    pix_pkg::pix_bus_t pix;
    ctrl_pkg::wb_req_t wb_req;
    ctrl_pkg::wb_rsp_t wb_rsp;

    logic [31:0]        lfsr_state;
    string              current_test;
    int                 cycle_count = 0;
    pix_pkg::pix_word_t block_data [pix_pkg::BLOCK_COUNT][pix_pkg::IMAGE_SIZE];

    tb_clock #(.PERIOD_NS(100), .RESET_CYCLES(8), .DRIVE_DELAY(DRIVE_DELAY)) clock0 (
        .clk(clk), .fifoIn_rst(fifoIn_rst)
    );

    pix_controller dut0 (
        .clk(clk), .fifoIn_rst(fifoIn_rst), .pix(pix), .wb_req(wb_req), .wb_rsp(wb_rsp)
    );

    // ==============================
    // Helpers
    // ==============================
    // Galois form of taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    function automatic logic [pix_pkg::PIX_BITS-1:0] random_pixel();
        logic [pix_pkg::PIX_BITS-1:0] value;
        value = '0;
        for (int i = 0; i < pix_pkg::PIX_BITS; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[pix_pkg::PIX_BITS-2:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic ctrl_pkg::status_t status_of(logic done, logic dropped, logic started);
        ctrl_pkg::status_t status;
        status                 = '0;
        status.capture_done    = done;
        status.pixel_dropped   = dropped;
        status.readout_started = started;
        return status;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic report_error(string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_word(string what, pix_pkg::pix_word_t expected,
                              pix_pkg::pix_word_t actual);
        if (actual !== expected) begin
            report_error($sformatf("FAIL %s %s expected %h actual %h",
                                   current_test, what, expected, actual));
        end
    endtask

    task automatic check_status(string what, ctrl_pkg::status_t expected,
                                ctrl_pkg::status_t actual);
        if (actual !== expected) begin
            report_error($sformatf("FAIL %s %s expected %h actual %h",
                                   current_test, what, expected, actual));
        end
    endtask

    // ==============================
    // Wishbone master
    // ==============================
    task automatic wait_ack();
        next_cycle();
        while (wb_rsp.ack !== 1'b1) begin
            next_cycle();
        end
    endtask

    task automatic wb_write(logic [3:0] addr, logic [15:0] data);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: addr, dat: data};
        wait_ack();
        // Hold the request through the edge where ack is taken
        next_cycle();
        wb_req = '0;
    endtask

    task automatic wb_read(logic [3:0] addr, output logic [15:0] data);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: addr, dat: 16'h0000};
        wait_ack();
        data = wb_rsp.dat;
        next_cycle();
        wb_req = '0;
    endtask

    task automatic read_status(output ctrl_pkg::status_t status);
        logic [15:0] data;
        wb_read(ctrl_pkg::ADDR_STATUS, data);
        status = ctrl_pkg::status_t'(data);
    endtask

    task automatic issue_command(ctrl_pkg::cmd_e op, pix_pkg::blk_t blk);
        logic [15:0] data;
        data      = '0;
        data[1:0] = op;
        data[4:3] = blk;
        wb_write(ctrl_pkg::ADDR_CMD, data);
    endtask

    // ==============================
    // Sensor side
    // ==============================
    task automatic pixel_cycle(logic fv, logic lv, logic [pix_pkg::PIX_BITS-1:0] data);
        pix.fv   = fv;
        pix.lv   = lv;
        pix.data = data;
        next_cycle();
    endtask

    task automatic send_frame(pix_pkg::blk_t blk, logic gapped);
        logic [pix_pkg::PIX_BITS-1:0] value;
        repeat (LEAD_IN) pixel_cycle(1'b0, 1'b0, '0);
        pixel_cycle(1'b1, 1'b0, '0);
        for (int idx = 0; idx < pix_pkg::IMAGE_SIZE; idx++) begin
            if (gapped && idx != 0 && idx % LINE_LEN == 0) begin
                repeat (LINE_GAP) pixel_cycle(1'b1, 1'b0, '0);
            end
            value                = random_pixel();
            block_data[blk][idx] = {4'h0, value};
            pixel_cycle(1'b1, 1'b1, value);
        end
        pixel_cycle(1'b1, 1'b0, '0);
        repeat (TAIL) pixel_cycle(1'b0, 1'b0, '0);
    endtask

    task automatic finish_capture();
        ctrl_pkg::status_t status;
        read_status(status);
        while (!status.capture_done) begin
            read_status(status);
        end
        check_status("after capture", status_of(1'b1, 1'b0, 1'b0), status);
    endtask

    task automatic capture_block(pix_pkg::blk_t blk);
        issue_command(ctrl_pkg::CMD_CAPTURE, blk);
        send_frame(blk, 1'b1);
        finish_capture();
    endtask

    task automatic readout_block(pix_pkg::blk_t blk, int gap);
        ctrl_pkg::status_t status;
        logic [15:0]       data;
        issue_command(ctrl_pkg::CMD_READOUT, blk);
        read_status(status);
        check_status("after readout command", status_of(1'b1, 1'b0, 1'b1), status);
        for (int idx = 0; idx < pix_pkg::IMAGE_SIZE; idx++) begin
            wb_read(ctrl_pkg::ADDR_DATA, data);
            check_word($sformatf("block %0d word %0d", blk, idx), block_data[blk][idx], data);
            repeat (gap) next_cycle();
        end
    endtask

    // ==============================
    // Directed tests
    // ==============================
    task automatic reset_status_test();
        ctrl_pkg::status_t status;
        current_test = "reset_status";
        read_status(status);
        check_status("after reset", status_of(1'b0, 1'b0, 1'b0), status);
    endtask

    task automatic single_block_test();
        current_test = "single_block";
        capture_block(2'd0);
        readout_block(2'd0, 0);
    endtask

    task automatic two_block_test();
        current_test = "two_blocks";
        capture_block(2'd1);
        capture_block(2'd2);
        readout_block(2'd2, 0);
        readout_block(2'd1, 0);
    endtask

    task automatic skip_running_frame_test();
        current_test = "skip_running_frame";
        repeat (4) pixel_cycle(1'b1, 1'b0, '0);
        issue_command(ctrl_pkg::CMD_CAPTURE, 2'd3);
        // Tail of a frame that began before the arm
        repeat (2) begin
            repeat (LINE_LEN) pixel_cycle(1'b1, 1'b1, random_pixel());
            repeat (LINE_GAP) pixel_cycle(1'b1, 1'b0, '0);
        end
        send_frame(2'd3, 1'b1);
        finish_capture();
        readout_block(2'd3, 0);
    endtask

    task automatic overflow_test();
        ctrl_pkg::status_t status;
        current_test = "overflow";
        issue_command(ctrl_pkg::CMD_CAPTURE, 2'd0);
        send_frame(2'd0, 1'b0);
        // Let the input FIFO drain past a refresh window
        repeat (pix_pkg::REFRESH_INTERVAL) next_cycle();
        read_status(status);
        check_status("after overflow frame", status_of(1'b0, 1'b1, 1'b0), status);
        capture_block(2'd0);
        readout_block(2'd0, 0);
    endtask

    task automatic slow_readout_test();
        current_test = "slow_readout";
        capture_block(2'd2);
        readout_block(2'd2, SLOW_GAP);
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            report_error($sformatf("Timeout, the tests did not finish within %0d clock cycles",
                                   TIMEOUT_CYCLES));
        end
    end

    initial begin
        pix        = '0;
        wb_req     = '0;
        lfsr_state = 32'd66006;
        wait (fifoIn_rst === 1'b1);
        next_cycle();

        reset_status_test();
        single_block_test();
        two_block_test();
        skip_running_frame_test();
        overflow_test();
        slow_readout_test();

        $display("Test passed");
        $finish;
    end

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 8,
    parameter int DRIVE_DELAY  = 10
) (
    output logic clk,
    output logic fifoIn_rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release lines up with the stimulus drive point
    initial begin
        fifoIn_rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY) fifoIn_rst = 1'b1;
    end

endmodule
